/* build.f */
source/fp16_pkg.sv
source/fp16_pack.sv
source/fp16_mul.sv
source/fp16_add.sv
source/fp16_dot2.sv
tests/fp16_dot2_checker.sv
tests/fp16_dot2_tb.sv

/* source/fp16_add.sv */
`timescale 1ns/1ps

module fp16_add (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      start,
    input  logic [fp16_pkg::fp_w-1:0] x,
    input  logic [fp16_pkg::fp_w-1:0] y,
    input  logic                      ovf_in,
    output logic [fp16_pkg::fp_w-1:0] sum,
    output logic                      ovf,
    output logic                      ready
);
    import fp16_pkg::*;

    logic run_latched;
    logic run;
    logic s1_valid, s2_valid;

    // operand unpack
    logic [exp_w-1:0] exp_x, exp_y;
    logic [sig_w-1:0] sig_x, sig_y;
    logic             x_big;
    logic [exp_w-1:0] shift;

    // stage 1 registers, aligned operands
    logic             s1_sign_big, s1_sign_small;
    logic [sig_w-1:0] s1_sig_big, s1_sig_small;
    logic [exp_w-1:0] s1_exp;
    logic             s1_ovf;

    // stage 2 registers, signed magnitude sum
    logic             s2_sign;
    logic [sig_w-1:0] s2_mag;
    logic             s2_carry;
    logic [exp_w-1:0] s2_exp;
    logic             s2_ovf;

    // stage 3 pack inputs and results
    logic [sig_w-1:0]        pk_sig;
    logic signed [exp_w+1:0] pk_exp;
    logic                    pk_sign;
    logic [fp_w-1:0]         pk_value;
    logic                    pk_ovf;

    // run stays up while anything will still sit in the pipe after this edge
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            run_latched <= 1'b0;
        end
        else begin
            run_latched <= start | s1_valid | s2_valid;
        end
    end

    assign run = run_latched | start;   // no dead cycle on the first start

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            ready    <= 1'b0;
        end
        else if (run) begin
            s1_valid <= start;
            s2_valid <= s1_valid;
            ready    <= s2_valid;
        end
    end

    assign exp_x = x[fp_w-2 -: exp_w];
    assign exp_y = y[fp_w-2 -: exp_w];
    assign sig_x = (exp_x == '0) ? '0 : {1'b1, x[frac_w-1:0], 2'b00};
    assign sig_y = (exp_y == '0) ? '0 : {1'b1, y[frac_w-1:0], 2'b00};

    assign x_big = (exp_x >= exp_y);
    assign shift = x_big ? (exp_x - exp_y) : (exp_y - exp_x);

    // stage 1, align; bits shifted out are lost
    always_ff @(posedge clk) begin
        if (run) begin
            s1_sign_big   <= x_big ? x[fp_w-1] : y[fp_w-1];
            s1_sign_small <= x_big ? y[fp_w-1] : x[fp_w-1];
            s1_sig_big    <= x_big ? sig_x : sig_y;
            s1_sig_small  <= (x_big ? sig_y : sig_x) >> shift;
            s1_exp        <= x_big ? exp_x : exp_y;
            s1_ovf        <= ovf_in;
        end
    end

    // stage 2, add or subtract magnitudes
    always_ff @(posedge clk) begin
        if (run) begin
            if (s1_sign_big == s1_sign_small) begin
                {s2_carry, s2_mag} <= s1_sig_big + s1_sig_small;
                s2_sign            <= s1_sign_big;
            end
            else if (s1_sig_big >= s1_sig_small) begin
                s2_carry <= 1'b0;
                s2_mag   <= s1_sig_big - s1_sig_small;
                s2_sign  <= s1_sign_big;
            end
            else begin                          // only with equal exponents
                s2_carry <= 1'b0;
                s2_mag   <= s1_sig_small - s1_sig_big;
                s2_sign  <= s1_sign_small;
            end
            s2_exp <= s1_exp;
            s2_ovf <= s1_ovf;
        end
    end

    // fold the carry back into the significand before packing
    assign pk_sig  = s2_carry ? {1'b1, s2_mag[sig_w-1:1]} : s2_mag;
    assign pk_exp  = $signed({2'b00, s2_exp}) + $signed({6'b0, s2_carry});
    assign pk_sign = (s2_mag == '0 && !s2_carry) ? 1'b0 : s2_sign;   // cancellation gives +0

    fp16_pack i_pack (
        .sign   (pk_sign),
        .exp    (pk_exp),
        .sig    (pk_sig),
        .ovf_in (s2_ovf),
        .value  (pk_value),
        .ovf    (pk_ovf)
    );

    // stage 3, result holds until the next item completes
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            sum <= '0;
            ovf <= 1'b0;
        end
        else if (run && s2_valid) begin
            sum <= pk_value;
            ovf <= pk_ovf;
        end
    end

endmodule

/* source/fp16_dot2.sv */
`timescale 1ns/1ps

module fp16_dot2 (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      start,
    input  logic [fp16_pkg::fp_w-1:0] a0,
    input  logic [fp16_pkg::fp_w-1:0] b0,
    input  logic [fp16_pkg::fp_w-1:0] a1,
    input  logic [fp16_pkg::fp_w-1:0] b1,
    output logic [fp16_pkg::fp_w-1:0] result,
    output logic                      overflow,
    output logic                      ready
);
    import fp16_pkg::*;

    logic [fp_w-1:0] prod0, prod1;
    logic            prod0_ovf, prod1_ovf;
    logic            prod_valid;

    fp16_mul i_mul0 (
        .clk       (clk),
        .nRST      (nRST),
        .start     (start),
        .a         (a0),
        .b         (b0),
        .product   (prod0),
        .ovf       (prod0_ovf),
        .out_valid (prod_valid)
    );

    // both multipliers run in lockstep, so one valid is enough
    fp16_mul i_mul1 (
        .clk       (clk),
        .nRST      (nRST),
        .start     (start),
        .a         (a1),
        .b         (b1),
        .product   (prod1),
        .ovf       (prod1_ovf),
        .out_valid ()
    );

    fp16_add i_add (
        .clk    (clk),
        .nRST   (nRST),
        .start  (prod_valid),
        .x      (prod0),
        .y      (prod1),
        .ovf_in (prod0_ovf | prod1_ovf),    // either product overflowing forces infinity
        .sum    (result),
        .ovf    (overflow),
        .ready  (ready)
    );

endmodule

/* source/fp16_mul.sv */
`timescale 1ns/1ps

module fp16_mul (
    input  logic                      clk,
    input  logic                      nRST,
    input  logic                      start,
    input  logic [fp16_pkg::fp_w-1:0] a,
    input  logic [fp16_pkg::fp_w-1:0] b,
    output logic [fp16_pkg::fp_w-1:0] product,
    output logic                      ovf,
    output logic                      out_valid
);
    import fp16_pkg::*;

    logic [exp_w-1:0] exp_a, exp_b;
    logic [frac_w:0]  man_a, man_b;     // hidden bit included

    // stage 1 registers
    logic                    s1_valid;
    logic                    s1_sign;
    logic signed [exp_w+1:0] s1_exp;
    logic [2*frac_w+1:0]     s1_prod;

    // stage 2 pack results
    logic [fp_w-1:0] pk_value;
    logic            pk_ovf;

    assign exp_a = a[fp_w-2 -: exp_w];
    assign exp_b = b[fp_w-2 -: exp_w];

    // a zero exponent means zero or subnormal, both flushed
    assign man_a = (exp_a == '0) ? '0 : {1'b1, a[frac_w-1:0]};
    assign man_b = (exp_b == '0) ? '0 : {1'b1, b[frac_w-1:0]};

    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end
        else begin
            if (start | s1_valid) begin
                s1_valid <= start;
            end
            if (s1_valid | out_valid) begin
                out_valid <= s1_valid;
            end
        end
    end

    // stage 1 payload
    always_ff @(posedge clk) begin
        if (start | s1_valid) begin
            s1_sign <= a[fp_w-1] ^ b[fp_w-1];
            // the product's top bit is the 2's place, hence the extra +1
            s1_exp  <= $signed({2'b00, exp_a}) + $signed({2'b00, exp_b})
                       - $signed({2'b00, exp_bias}) + 7'sd1;
            s1_prod <= man_a * man_b;
        end
    end

    fp16_pack i_pack (
        .sign   (s1_sign),
        .exp    (s1_exp),
        .sig    (s1_prod[2*frac_w+1 -: sig_w]),   // low product bits truncated
        .ovf_in (1'b0),
        .value  (pk_value),
        .ovf    (pk_ovf)
    );

    // stage 2, output only changes when a new product arrives
    always_ff @(posedge clk, negedge nRST) begin
        if (nRST == 1'b0) begin
            product <= '0;
            ovf     <= 1'b0;
        end
        else if (s1_valid) begin
            product <= pk_value;
            ovf     <= pk_ovf;
        end
    end

endmodule

/* source/fp16_pack.sv */
`timescale 1ns/1ps

// sig is read with its hidden position at bit sig_w-1, so the input value is
// sig / 2**(sig_w-1) * 2**(exp - bias)
module fp16_pack (
    input  logic                              sign,
    input  logic signed [fp16_pkg::exp_w+1:0] exp,
    input  logic [fp16_pkg::sig_w-1:0]        sig,
    input  logic                              ovf_in,
    output logic [fp16_pkg::fp_w-1:0]         value,
    output logic                              ovf
);
    import fp16_pkg::*;

    logic [3:0]              lz;        // distance of leading one below the hidden position
    logic [sig_w-1:0]        sig_n;
    logic signed [exp_w+1:0] exp_n;

    // leading one search, highest set bit wins
    always_comb begin
        lz = '0;
        for (int i = 0; i < sig_w; i++) begin
            if (sig[i]) begin
                lz = 4'(sig_w - 1 - i);
            end
        end
    end

    assign sig_n = sig << lz;
    assign exp_n = exp - $signed({3'b000, lz});

    always_comb begin
        ovf = 1'b0;
        if (ovf_in) begin                               // upstream overflow wins
            value = fp_pos_inf;
            ovf   = 1'b1;
        end
        else if (sig == '0) begin
            value = {sign, {(fp_w-1){1'b0}}};
        end
        else if (exp_n >= exp_max) begin
            value = fp_pos_inf;
            ovf   = 1'b1;
        end
        else if (exp_n <= 0) begin                      // flush subnormal to zero
            value = {sign, {(fp_w-1){1'b0}}};
        end
        else begin
            // low guard bits are simply dropped, truncation
            value = {sign, exp_n[exp_w-1:0], sig_n[sig_w-2 -: frac_w]};
        end
    end

endmodule

/* source/fp16_pkg.sv */
package fp16_pkg;

    // binary16 word layout
    localparam int fp_w   = 16;
    localparam int exp_w  = 5;
    localparam int frac_w = 10;

    localparam logic [exp_w-1:0] exp_bias = 5'd15;
    localparam int exp_max = 31;                     // all-ones exponent, infinity

    // overflow result, positive infinity
    localparam logic [fp_w-1:0] fp_pos_inf = 16'h7c00;

    // adder working significand: hidden bit, fraction, two guard bits
    localparam int sig_w = frac_w + 3;

    // pipeline depths in cycles
    localparam int mul_lat = 2;
    localparam int add_lat = 3;
    localparam int dot_lat = mul_lat + add_lat;      // start to ready at the top level

endpackage

/* tests/fp16_dot2_checker.sv */
`timescale 1ns/1ps

module fp16_dot2_checker (
    input logic                      clk,
    input logic                      nRST,
    input logic                      start,
    input logic                      ready,
    input logic                      overflow,
    input logic [fp16_pkg::fp_w-1:0] result
);
    import fp16_pkg::*;

    int fail_count = 0;     // the testbench watches this

    // every start comes out exactly dot_lat cycles later
    property start_gives_ready;
        @(posedge clk) disable iff (!nRST) start |-> ##dot_lat ready;
    endproperty

    // no ready without a matching start
    property ready_needs_start;
        @(posedge clk) disable iff (!nRST) ready |-> $past(start, dot_lat);
    endproperty

    property overflow_is_inf;
        @(posedge clk) disable iff (!nRST) overflow |-> (result == fp_pos_inf);
    endproperty

    property quiet_in_reset;
        @(posedge clk) !nRST |-> (!ready && !overflow);
    endproperty

    assert property (start_gives_ready) else begin
        $error("no ready %0d cycles after start", dot_lat);
        fail_count++;
    end

    assert property (ready_needs_start) else begin
        $error("ready without a start %0d cycles earlier", dot_lat);
        fail_count++;
    end

    assert property (overflow_is_inf) else begin
        $error("overflow high but result is %h", result);
        fail_count++;
    end

    assert property (quiet_in_reset) else begin
        $error("ready or overflow high during reset");
        fail_count++;
    end

endmodule

bind fp16_dot2 fp16_dot2_checker i_checker (
    .clk      (clk),
    .nRST     (nRST),
    .start    (start),
    .ready    (ready),
    .overflow (overflow),
    .result   (result)
);

/* tests/fp16_dot2_tb.sv */
`timescale 1ns/1ps

module fp16_dot2_tb;
    import fp16_pkg::*;

    localparam int n_random = 20;
    localparam int n_cancel = 4;
    localparam int n_ovf    = 2;
    localparam int n_burst  = 8;
    localparam int n_items  = n_random + n_cancel + n_ovf + n_burst;
    localparam int reset_cycles = 16;
    localparam int cycle_limit  = reset_cycles + n_items * (dot_lat + 2) + 100;

    logic            clk;
    logic            nRST;
    logic            start;
    logic [fp_w-1:0] a0, b0, a1, b1;
    logic [fp_w-1:0] result;
    logic            overflow;
    logic            ready;

    logic [31:0]     lfsr_state = 32'heb76;
    int              cycle_count = 0;

    // expected results, oldest first
    logic [fp_w-1:0] exp_val_q[$];
    logic            exp_ovf_q[$];
    string           name_q[$];

    fp16_dot2 i_dut (
        .clk      (clk),
        .nRST     (nRST),
        .start    (start),
        .a0       (a0),
        .b0       (b0),
        .a1       (a1),
        .b1       (b1),
        .result   (result),
        .overflow (overflow),
        .ready    (ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic int rand_small();
        int mag;
        logic neg;
        mag = int'(rand_bits(5));          // 0..31
        neg = (rand_bits(1) != 0);
        return neg ? -mag : mag;
    endfunction

    // exact for magnitudes below 2048
    function automatic logic [fp_w-1:0] int_to_fp16(input int v);
        int mag;
        int p;
        logic [exp_w-1:0] e;
        logic [frac_w-1:0] f;
        mag = (v < 0) ? -v : v;
        if (mag == 0) begin
            return '0;
        end
        p = 0;
        for (int i = 0; i < 31; i++) begin
            if (mag[i]) p = i;
        end
        e = exp_w'(p + int'(exp_bias));
        f = frac_w'(mag << (frac_w - p));  // hidden bit falls off the top
        return {(v < 0), e, f};
    endfunction

    task automatic abort_run();
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    task automatic send_words(input logic [fp_w-1:0] w0, input logic [fp_w-1:0] w1,
                              input logic [fp_w-1:0] w2, input logic [fp_w-1:0] w3,
                              input logic [fp_w-1:0] exp_val, input logic exp_ovf,
                              input string name);
        @(posedge clk);
        start <= 1'b1;
        a0    <= w0;
        b0    <= w1;
        a1    <= w2;
        b1    <= w3;
        exp_val_q.push_back(exp_val);
        exp_ovf_q.push_back(exp_ovf);
        name_q.push_back(name);
    endtask

    task automatic send_ints(input int x0, input int y0, input int x1, input int y1,
                             input string name);
        send_words(int_to_fp16(x0), int_to_fp16(y0), int_to_fp16(x1), int_to_fp16(y1),
                   int_to_fp16(x0 * y0 + x1 * y1), 1'b0, name);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            start <= 1'b0;
        end
    endtask

    // outputs read at the edge hold the previous cycle's registered values
    always @(posedge clk) begin
        if (nRST && ready) begin
            assert (exp_val_q.size() != 0) else begin
                $display("ready pulse with no result outstanding");
                abort_run();
            end
            assert (result == exp_val_q[0]) else begin
                $display("mismatch %s: expected %h actual %h", name_q[0], exp_val_q[0], result);
                abort_run();
            end
            assert (overflow == exp_ovf_q[0]) else begin
                $display("mismatch %s overflow: expected %b actual %b",
                         name_q[0], exp_ovf_q[0], overflow);
                abort_run();
            end
            void'(exp_val_q.pop_front());
            void'(exp_ovf_q.pop_front());
            void'(name_q.pop_front());
        end
    end

    always @(negedge clk) begin
        if (i_dut.i_checker.fail_count != 0) begin
            $display("bound assertion on the handshake or overflow failed");
            abort_run();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: results missing");
            abort_run();
        end
    end

    initial begin
        int x0;
        int y0;
        nRST  = 1'b0;
        start = 1'b0;
        a0    = '0;
        b0    = '0;
        a1    = '0;
        b1    = '0;
        repeat (reset_cycles) @(posedge clk);
        nRST <= 1'b1;
        idle(3);

        for (int i = 0; i < n_random; i++) begin
            send_ints(rand_small(), rand_small(), rand_small(), rand_small(),
                      $sformatf("random %0d", i));
            idle(1 + int'(rand_bits(2)));
        end

        // a1 = -a0, b1 = b0 cancels exactly
        for (int i = 0; i < n_cancel; i++) begin
            x0 = rand_small();
            y0 = rand_small();
            if (x0 == 0) x0 = 7;
            if (y0 == 0) y0 = -3;
            // odd items lead with a negative product so the zero sign is forced
            if ((x0 * y0 < 0) != (i % 2 == 1)) begin
                x0 = -x0;
            end
            send_ints(x0, y0, -x0, y0, $sformatf("cancel %0d", i));
            idle(2);
        end

        // 65504 x 2 overflows in the multiplier
        // -65504 x 1 would pull a plain sum back below the infinity exponent
        send_words(16'h7bff, 16'h4000, 16'hfbff, 16'h3c00, fp_pos_inf, 1'b1,
                   "product overflow");
        idle(2);
        // 60000 x 1 twice overflows in the adder
        send_words(16'h7b53, 16'h3c00, 16'h7b53, 16'h3c00, fp_pos_inf, 1'b1,
                   "sum overflow");
        idle(2);

        for (int i = 0; i < n_burst; i++) begin
            send_ints(rand_small(), rand_small(), rand_small(), rand_small(),
                      $sformatf("burst %0d", i));
        end
        idle(1);

        while (exp_val_q.size() != 0) @(posedge clk);
        repeat (dot_lat + 2) @(posedge clk);

        if (i_dut.i_checker.fail_count == 0) begin
            $display("STATUS: PASS");
            $finish;
        end
        else begin
            abort_run();
        end
    end

endmodule
